// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int word_width = 32;
	localparam int inst_width = 6;

	// instruction numbers as seen by the execute stage.
	typedef enum logic [inst_width-1:0] {
		inst_nop  = 6'd0,
		inst_halt = 6'd4,
		inst_add  = 6'd8,
		inst_sub  = 6'd9,
		inst_addi = 6'd10,
		inst_mul  = 6'd12,
		inst_and  = 6'd16,
		inst_or   = 6'd17,
		inst_xor  = 6'd18,
		inst_sll  = 6'd20,
		inst_srl  = 6'd21,
		inst_lui  = 6'd22,
		inst_lw   = 6'd28,
		inst_sw   = 6'd29,
		inst_beq  = 6'd32,
		inst_bne  = 6'd33,
		inst_j    = 6'd34,
		inst_jr   = 6'd35
	} inst_num_e;

	typedef enum logic [2:0] {
		cat_none,
		cat_misc,
		cat_addsub,
		cat_muldiv,
		cat_bit,
		cat_mem,
		cat_branch
	} category_e;

	// each category runs from its first number up to the next one.
	localparam int misc_first = 4;
	localparam int addsub_first = 8;
	localparam int muldiv_first = 12;
	localparam int bit_first = 16;
	localparam int mem_first = 28;
	localparam int branch_first = 32;
	localparam int branch_last = 47;

endpackage

`default_nettype wire

// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

	// data memory geometry in words.
	localparam int mem_addr_width = 8;
	localparam int mem_depth = 256;

	// peers that share the data memory.
	typedef enum logic {
		exec,
		host
	} requester_e;

endpackage

`default_nettype wire

// File: mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
	import isa_pkg::*;

	logic valid;
	logic write;
	logic [word_width-1:0] addr;
	logic [word_width-1:0] wdata;
	logic ready;
	logic [word_width-1:0] rdata;
	logic rvalid;

	modport requester (output valid, write, addr, wdata, input ready, rdata, rvalid);

	// arbiter side facing a requester.
	modport arbiter (input valid, write, addr, wdata, output ready, rdata, rvalid);

	modport memory (input valid, write, addr, wdata, output ready, rdata, rvalid);

endinterface

`default_nettype wire

// File: alu_exec_element.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec_element (
	input logic clk,
	input logic reset,
	input logic [isa_pkg::inst_width-1:0] inst_num,
	input logic [isa_pkg::word_width-1:0] rs,
	input logic [isa_pkg::word_width-1:0] rt,
	input logic [isa_pkg::word_width-1:0] const16_x,
	input logic [15:0] const16,
	input logic [4:0] shift5,
	output logic completed,
	output logic [isa_pkg::word_width-1:0] out
);
	import isa_pkg::*;

	logic [word_width-1:0] result;
	logic done;

	always_comb begin
		case (inst_num)
			inst_add: result = rs + rt;
			inst_sub: result = rs - rt;
			inst_addi: result = rs + const16_x;
			inst_mul: result = rs * rt;
			inst_and: result = rs & rt;
			inst_or: result = rs | rt;
			inst_xor: result = rs ^ rt;
			inst_sll: result = rt << shift5;
			inst_srl: result = rt >> shift5;
			inst_lui: result = {const16, 16'h0000};
			default: result = '0;
		endcase
	end

	// one pulse on the first cycle out of reset.
	always_ff @(posedge clk) begin
		if (reset) begin
			completed <= 1'b0;
			done <= 1'b0;
		end else begin
			completed <= !done;
			done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!done)
			out <= result;
	end

endmodule

`default_nettype wire

// File: branch_exec_element.sv
`timescale 1ns/1ps
`default_nettype none

module branch_exec_element (
	input logic clk,
	input logic reset,
	input logic [isa_pkg::inst_width-1:0] inst_num,
	input logic [isa_pkg::word_width-1:0] pc,
	input logic [isa_pkg::word_width-1:0] rs,
	input logic [isa_pkg::word_width-1:0] rt,
	input logic [isa_pkg::word_width-1:0] const16_x,
	input logic [25:0] addr26,
	output logic completed,
	output logic [isa_pkg::word_width-1:0] reg_out,
	output logic [isa_pkg::word_width-1:0] pc_out
);
	import isa_pkg::*;

	logic [word_width-1:0] pc_plus4;
	logic [word_width-1:0] next_pc;
	logic done;

	always_comb begin
		pc_plus4 = pc + 4;
		case (inst_num)
			inst_beq: next_pc = (rs == rt) ? pc_plus4 + (const16_x << 2) : pc_plus4;
			inst_bne: next_pc = (rs != rt) ? pc_plus4 + (const16_x << 2) : pc_plus4;
			inst_j: next_pc = {pc_plus4[31:28], addr26, 2'b00};
			inst_jr: next_pc = rs;
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			completed <= 1'b0;
			done <= 1'b0;
		end else begin
			completed <= !done;
			done <= 1'b1;
		end
	end

	// link value goes out with the target.
	always_ff @(posedge clk) begin
		if (!done) begin
			pc_out <= next_pc;
			reg_out <= pc_plus4;
		end
	end

endmodule

`default_nettype wire

// File: mem_exec_element.sv
`timescale 1ns/1ps
`default_nettype none

module mem_exec_element (
	input logic clk,
	input logic reset,
	input logic [isa_pkg::inst_width-1:0] inst_num,
	input logic [isa_pkg::word_width-1:0] rs,
	input logic [isa_pkg::word_width-1:0] rt,
	input logic [isa_pkg::word_width-1:0] const16_x,
	output logic completed,
	output logic [isa_pkg::word_width-1:0] out,
	mem_bus_if.requester mem_bus
);
	import isa_pkg::*;

	typedef enum logic [1:0] {idle, request, wait_data, done} state_e;

	state_e state;
	logic [word_width-1:0] data_q;

	always_comb begin
		mem_bus.valid = (state == request);
		mem_bus.write = (inst_num == inst_sw);
		mem_bus.addr = rs + const16_x;
		mem_bus.wdata = rt;
		// a store ends one cycle after acceptance, a load at its response.
		completed = (state == wait_data) && (mem_bus.write || mem_bus.rvalid);
		out = (state == done) ? data_q : mem_bus.rdata;
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= idle;
		else begin
			case (state)
				idle: state <= request;
				request: if (mem_bus.ready) state <= wait_data;
				wait_data: if (completed) state <= done;
				default: state <= done;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == wait_data && mem_bus.rvalid)
			data_q <= mem_bus.rdata;
	end

	a_addr_stable: assert property (@(posedge clk) disable iff (reset)
		mem_bus.valid && !mem_bus.ready |=> mem_bus.valid && $stable(mem_bus.addr));

endmodule

`default_nettype wire

// File: executor.sv
`timescale 1ns/1ps
`default_nettype none

module executor (
	input logic clk,
	input logic reset,
	input logic [isa_pkg::word_width-1:0] pc,
	input logic [isa_pkg::inst_width-1:0] inst_num,
	input logic [15:0] const16,
	input logic [4:0] shift5,
	input logic [25:0] addr26,
	input logic [isa_pkg::word_width-1:0] general_in_regs [3],
	output logic completed,
	output logic halted,
	output logic [isa_pkg::word_width-1:0] exec_reg_out,
	output logic [isa_pkg::word_width-1:0] exec_pc_out,
	mem_bus_if.requester mem_bus
);
	import isa_pkg::*;

	category_e cat;
	logic [word_width-1:0] rs, rt, const16_x;
	logic alu_reset, branch_reset, mem_reset, misc_reset;
	logic alu_completed, branch_completed, mem_completed;
	logic [word_width-1:0] alu_out, mem_out, branch_reg_out, branch_pc_out;
	logic is_halt, halt_seen, halt_pulse;

	// ==================================================
	// category decode and element enables
	// ==================================================
	always_comb begin
		if (inst_num > branch_last) cat = cat_none;
		else if (inst_num >= branch_first) cat = cat_branch;
		else if (inst_num >= mem_first) cat = cat_mem;
		else if (inst_num >= bit_first) cat = cat_bit;
		else if (inst_num >= muldiv_first) cat = cat_muldiv;
		else if (inst_num >= addsub_first) cat = cat_addsub;
		else if (inst_num >= misc_first) cat = cat_misc;
		else cat = cat_none;

		rs = general_in_regs[0];
		rt = general_in_regs[1];
		const16_x = {{(word_width-16){const16[15]}}, const16};

		alu_reset = reset || !(cat == cat_addsub || cat == cat_muldiv || cat == cat_bit);
		branch_reset = reset || (cat != cat_branch);
		mem_reset = reset || (cat != cat_mem);
		misc_reset = reset || (cat != cat_misc);
		is_halt = (inst_num == inst_halt);
	end

	alu_exec_element alu_i (.clk, .reset(alu_reset), .inst_num, .rs, .rt, .const16_x,
		.const16, .shift5, .completed(alu_completed), .out(alu_out));

	branch_exec_element branch_i (.clk, .reset(branch_reset), .inst_num, .pc, .rs, .rt,
		.const16_x, .addr26, .completed(branch_completed), .reg_out(branch_reg_out),
		.pc_out(branch_pc_out));

	mem_exec_element mem_i (.clk, .reset(mem_reset), .inst_num, .rs, .rt, .const16_x,
		.completed(mem_completed), .out(mem_out), .mem_bus(mem_bus));

	// ==================================================
	// halt handling in place of a misc element
	// ==================================================
	always_ff @(posedge clk) begin
		if (reset)
			halted <= 1'b0;
		else if (is_halt)
			halted <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (misc_reset) begin
			halt_pulse <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			halt_pulse <= is_halt && !halt_seen;
			halt_seen <= halt_seen || is_halt;
		end
	end

	always_comb begin
		completed = alu_completed || branch_completed || mem_completed || halt_pulse;
		case (cat)
			cat_addsub, cat_muldiv, cat_bit: exec_reg_out = alu_out;
			cat_mem: exec_reg_out = mem_out;
			cat_branch: exec_reg_out = branch_reg_out;
			default: exec_reg_out = '0;
		endcase
		exec_pc_out = (cat == cat_branch) ? branch_pc_out : pc + 4;
	end

	a_one_completion: assert property (@(posedge clk) disable iff (reset)
		$onehot0({alu_completed, branch_completed, mem_completed, halt_pulse}));

endmodule

`default_nettype wire

// File: bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input logic clk,
	input logic reset,
	mem_bus_if.arbiter exec_bus,
	mem_bus_if.arbiter host_bus,
	mem_bus_if.requester mem_bus
);
	import bus_pkg::*;

	requester_e pick, owner, last;
	logic busy;

	always_comb begin
		// on a tie the peer not served last goes first.
		if (exec_bus.valid && host_bus.valid)
			pick = (last == exec) ? host : exec;
		else if (host_bus.valid)
			pick = host;
		else
			pick = exec;

		mem_bus.valid = !busy && ((pick == exec) ? exec_bus.valid : host_bus.valid);
		mem_bus.write = (pick == exec) ? exec_bus.write : host_bus.write;
		mem_bus.addr = (pick == exec) ? exec_bus.addr : host_bus.addr;
		mem_bus.wdata = (pick == exec) ? exec_bus.wdata : host_bus.wdata;

		exec_bus.ready = mem_bus.valid && mem_bus.ready && (pick == exec);
		host_bus.ready = mem_bus.valid && mem_bus.ready && (pick == host);
		exec_bus.rdata = mem_bus.rdata;
		host_bus.rdata = mem_bus.rdata;
		exec_bus.rvalid = busy && (owner == exec) && mem_bus.rvalid;
		host_bus.rvalid = busy && (owner == host) && mem_bus.rvalid;
	end

	// a read keeps its grant until the response has gone back.
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			owner <= exec;
			last <= host;
		end else if (busy && mem_bus.rvalid)
			busy <= 1'b0;
		else if (mem_bus.valid && mem_bus.ready) begin
			last <= pick;
			if (!mem_bus.write) begin
				busy <= 1'b1;
				owner <= pick;
			end
		end
	end

	a_single_ready: assert property (@(posedge clk) disable iff (reset)
		!(exec_bus.ready && host_bus.ready));

endmodule

`default_nettype wire

// File: data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
	input logic clk,
	input logic reset,
	mem_bus_if.memory mem_bus
);
	import isa_pkg::*;
	import bus_pkg::*;

	logic [word_width-1:0] mem [mem_depth];
	logic [mem_addr_width-1:0] index;

	// word index from the byte address.
	assign index = mem_bus.addr[mem_addr_width+1:2];

	always_ff @(posedge clk) begin
		if (mem_bus.valid && mem_bus.ready) begin
			if (mem_bus.write)
				mem[index] <= mem_bus.wdata;
			else
				mem_bus.rdata <= mem[index];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_bus.ready <= 1'b0;
			mem_bus.rvalid <= 1'b0;
		end else begin
			mem_bus.ready <= 1'b1;
			mem_bus.rvalid <= mem_bus.valid && mem_bus.ready && !mem_bus.write;
		end
	end

endmodule

`default_nettype wire

// File: exec_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_top (
	input logic clk,
	input logic reset,
	input logic [isa_pkg::word_width-1:0] pc,
	input logic [isa_pkg::inst_width-1:0] inst_num,
	input logic [15:0] const16,
	input logic [4:0] shift5,
	input logic [25:0] addr26,
	input logic [isa_pkg::word_width-1:0] general_in_regs [3],
	output logic completed,
	output logic halted,
	output logic [isa_pkg::word_width-1:0] exec_reg_out,
	output logic [isa_pkg::word_width-1:0] exec_pc_out,
	input logic host_valid,
	input logic host_write,
	input logic [isa_pkg::word_width-1:0] host_addr,
	input logic [isa_pkg::word_width-1:0] host_wdata,
	output logic host_ready,
	output logic [isa_pkg::word_width-1:0] host_rdata,
	output logic host_rvalid
);

	mem_bus_if exec_bus ();
	mem_bus_if host_bus ();
	mem_bus_if mem_bus ();

	// host port onto its bus.
	assign host_bus.valid = host_valid;
	assign host_bus.write = host_write;
	assign host_bus.addr = host_addr;
	assign host_bus.wdata = host_wdata;
	assign host_ready = host_bus.ready;
	assign host_rdata = host_bus.rdata;
	assign host_rvalid = host_bus.rvalid;

	executor executor_i (.clk, .reset, .pc, .inst_num, .const16, .shift5, .addr26,
		.general_in_regs, .completed, .halted, .exec_reg_out, .exec_pc_out,
		.mem_bus(exec_bus));

	bus_arbiter arbiter_i (.clk, .reset, .exec_bus(exec_bus), .host_bus(host_bus),
		.mem_bus(mem_bus));

	data_memory memory_i (.clk, .reset, .mem_bus(mem_bus));

endmodule

`default_nettype wire

// File: exec_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb;
	import isa_pkg::*;

	localparam int row_cycle_limit = 20;
	localparam int host_phase_cycles = 60;

	typedef struct packed {
		logic [31:0] pc;
		logic [5:0] op;
		logic [15:0] c16;
		logic [4:0] sh;
		logic [25:0] a26;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] r2;
		logic chk;
		logic [31:0] exp_reg;
		logic [31:0] exp_pc;
	} row_t;

	logic clk;
	logic reset;
	logic [word_width-1:0] pc;
	logic [inst_width-1:0] inst_num;
	logic [15:0] const16;
	logic [4:0] shift5;
	logic [25:0] addr26;
	logic [word_width-1:0] general_in_regs [3];
	logic completed;
	logic halted;
	logic [word_width-1:0] exec_reg_out;
	logic [word_width-1:0] exec_pc_out;
	logic host_valid;
	logic host_write;
	logic [word_width-1:0] host_addr;
	logic [word_width-1:0] host_wdata;
	logic host_ready;
	logic [word_width-1:0] host_rdata;
	logic host_rvalid;

	row_t rows [$];
	inst_num_e alu_ops [10] = '{inst_add, inst_sub, inst_addi, inst_mul, inst_and,
		inst_or, inst_xor, inst_sll, inst_srl, inst_lui};
	int alu_end, branch_end, mem_end, contend_row, halt_row;
	int checks, errors, tests, failed_tests, test_errs;
	int cycles, cycle_limit;

	exec_unit_top dut_i (.clk, .reset, .pc, .inst_num, .const16, .shift5, .addr26,
		.general_in_regs, .completed, .halted, .exec_reg_out, .exec_pc_out,
		.host_valid, .host_write, .host_addr, .host_wdata, .host_ready, .host_rdata,
		.host_rvalid);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("run stopped after %0d cycles without reaching the end", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] sext16(input logic [15:0] c);
		return {{16{c[15]}}, c};
	endfunction

	// reference results for the integer operations.
	function automatic logic [31:0] alu_expect(input logic [5:0] op, input logic [31:0] rs_v,
		input logic [31:0] rt_v, input logic [15:0] c, input logic [4:0] sh);
		case (op)
			inst_add: return rs_v + rt_v;
			inst_sub: return rs_v - rt_v;
			inst_addi: return rs_v + sext16(c);
			inst_mul: return rs_v * rt_v;
			inst_and: return rs_v & rt_v;
			inst_or: return rs_v | rt_v;
			inst_xor: return rs_v ^ rt_v;
			inst_sll: return rt_v << sh;
			inst_srl: return rt_v >> sh;
			inst_lui: return {c, 16'h0000};
			default: return 32'h0;
		endcase
	endfunction

	// preload pattern that depends on every address bit.
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e3779b1) ^ 32'h5a5a5a5a;
	endfunction

	function automatic void add_row(input logic [31:0] r_pc, input logic [5:0] op,
		input logic [15:0] c16, input logic [4:0] sh, input logic [25:0] a26,
		input logic [31:0] rs_v, input logic [31:0] rt_v, input logic chk,
		input logic [31:0] exp_reg, input logic [31:0] exp_pc);
		row_t r;
		r.pc = r_pc;
		r.op = op;
		r.c16 = c16;
		r.sh = sh;
		r.a26 = a26;
		r.rs = rs_v;
		r.rt = rt_v;
		r.r2 = rs_v ^ rt_v;
		r.chk = chk;
		r.exp_reg = exp_reg;
		r.exp_pc = exp_pc;
		rows.push_back(r);
	endfunction

	// ==================================================
	// stimulus table
	// ==================================================
	task automatic build_table();
		logic [31:0] a;
		logic [31:0] b;
		logic [15:0] c;
		logic [4:0] s;
		add_row(32'h100, inst_add, 16'h0, 5'd0, 26'h0, 32'd5, 32'd7, 1'b1, 32'd12, 32'h104);
		add_row(32'h100, inst_sub, 16'h0, 5'd0, 26'h0, 32'd3, 32'd5, 1'b1, 32'hfffffffe, 32'h104);
		add_row(32'h100, inst_addi, 16'hffff, 5'd0, 26'h0, 32'd100, 32'd0, 1'b1, 32'd99, 32'h104);
		add_row(32'h100, inst_mul, 16'h0, 5'd0, 26'h0, 32'h10000, 32'h30, 1'b1, 32'h300000, 32'h104);
		add_row(32'h100, inst_and, 16'h0, 5'd0, 26'h0, 32'hf0f0f0f0, 32'hff00ff00, 1'b1,
			32'hf000f000, 32'h104);
		add_row(32'h100, inst_or, 16'h0, 5'd0, 26'h0, 32'hf0f0f0f0, 32'h0f0f0000, 1'b1,
			32'hfffff0f0, 32'h104);
		add_row(32'h100, inst_xor, 16'h0, 5'd0, 26'h0, 32'hffff0000, 32'h0f0f0f0f, 1'b1,
			32'hf0f00f0f, 32'h104);
		add_row(32'h100, inst_sll, 16'h0, 5'd4, 26'h0, 32'h0, 32'h1, 1'b1, 32'h10, 32'h104);
		add_row(32'h100, inst_srl, 16'h0, 5'd31, 26'h0, 32'h0, 32'h80000000, 1'b1, 32'h1, 32'h104);
		add_row(32'h100, inst_lui, 16'h1234, 5'd0, 26'h0, 32'h0, 32'h0, 1'b1, 32'h12340000, 32'h104);
		foreach (alu_ops[i]) begin
			a = $urandom;
			b = $urandom;
			c = 16'($urandom);
			s = 5'($urandom);
			add_row(32'h180, alu_ops[i], c, s, 26'h0, a, b, 1'b1,
				alu_expect(alu_ops[i], a, b, c, s), 32'h184);
		end
		alu_end = rows.size();
		add_row(32'h200, inst_beq, 16'h0010, 5'd0, 26'h0, 32'd9, 32'd9, 1'b1, 32'h204, 32'h244);
		add_row(32'h200, inst_beq, 16'h0010, 5'd0, 26'h0, 32'd1, 32'd2, 1'b1, 32'h204, 32'h204);
		add_row(32'h200, inst_bne, 16'hfffe, 5'd0, 26'h0, 32'd1, 32'd2, 1'b1, 32'h204, 32'h1fc);
		add_row(32'h200, inst_bne, 16'h0010, 5'd0, 26'h0, 32'd3, 32'd3, 1'b1, 32'h204, 32'h204);
		add_row(32'h30000100, inst_j, 16'h0, 5'd0, 26'h0abcde, 32'h0, 32'h0, 1'b1, 32'h30000104,
			32'h302af378);
		add_row(32'h400, inst_jr, 16'h0, 5'd0, 26'h0, 32'h1234, 32'h0, 1'b1, 32'h404, 32'h1234);
		branch_end = rows.size();
		add_row(32'h300, inst_lw, 16'h0008, 5'd0, 26'h0, 32'h40, 32'h0, 1'b1, fill_word(32'h48), 32'h304);
		add_row(32'h300, inst_lw, 16'hfffc, 5'd0, 26'h0, 32'h60, 32'h0, 1'b1, fill_word(32'h5c), 32'h304);
		add_row(32'h300, inst_sw, 16'h0004, 5'd0, 26'h0, 32'h80, 32'hdeadbeef, 1'b0, 32'h0, 32'h304);
		add_row(32'h300, inst_lw, 16'h0004, 5'd0, 26'h0, 32'h80, 32'h0, 1'b1, 32'hdeadbeef, 32'h304);
		mem_end = rows.size();
		contend_row = rows.size();
		add_row(32'h340, inst_lw, 16'h0, 5'd0, 26'h0, 32'h50, 32'h0, 1'b1, fill_word(32'h50), 32'h344);
		halt_row = rows.size();
		add_row(32'h500, inst_halt, 16'h0, 5'd0, 26'h0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h504);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("at %0t: %s", $time, what);
		errors++;
		test_errs++;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (test_errs == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, test_errs);
			failed_tests++;
		end
		test_errs = 0;
	endtask

	// ==================================================
	// executor and host port drivers
	// ==================================================
	task automatic run_row(input int idx);
		row_t r;
		bit seen;
		int n;
		r = rows[idx];
		pc = r.pc;
		inst_num = r.op;
		const16 = r.c16;
		shift5 = r.sh;
		addr26 = r.a26;
		general_in_regs[0] = r.rs;
		general_in_regs[1] = r.rt;
		general_in_regs[2] = r.r2;
		seen = 1'b0;
		n = 0;
		while (!seen && n < row_cycle_limit) begin
			@(negedge clk);
			seen = completed;
			n++;
		end
		if (!seen) begin
			report_problem($sformatf("row %0d never raised completed", idx));
		end else begin
			if (r.chk)
				check_value("exec_reg_out", exec_reg_out, r.exp_reg);
			check_value("exec_pc_out", exec_pc_out, r.exp_pc);
		end
		// one nop cycle puts the element back in reset.
		@(posedge clk);
		#1;
		inst_num = inst_nop;
		@(posedge clk);
		#1;
	endtask

	task automatic host_transfer(input logic wr, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		bit ok;
		int n;
		host_valid = 1'b1;
		host_write = wr;
		host_addr = addr;
		host_wdata = wdata;
		rdata = 32'h0;
		ok = 1'b0;
		n = 0;
		while (!ok && n < row_cycle_limit) begin
			@(negedge clk);
			ok = host_ready;
			n++;
		end
		@(posedge clk);
		#1;
		host_valid = 1'b0;
		if (!ok) begin
			report_problem($sformatf("host access to %h was never accepted", addr));
		end else if (!wr) begin
			@(negedge clk);
			if (!host_rvalid)
				report_problem($sformatf("host read of %h got no response", addr));
			rdata = host_rdata;
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		logic [31:0] hdata;
		void'($urandom(74913));
		cycles = 0;
		cycle_limit = 0;
		checks = 0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		test_errs = 0;
		reset = 1'b1;
		pc = '0;
		inst_num = inst_nop;
		const16 = '0;
		shift5 = '0;
		addr26 = '0;
		general_in_regs[0] = '0;
		general_in_regs[1] = '0;
		general_in_regs[2] = '0;
		host_valid = 1'b0;
		host_write = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		build_table();
		cycle_limit = rows.size() * row_cycle_limit + host_phase_cycles + 100;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int k = 0; k < 8; k++)
			host_transfer(1'b1, 32'h40 + 4 * k, fill_word(32'h40 + 4 * k), hdata);

		for (int i = 0; i < alu_end; i++)
			run_row(i);
		finish_test("alu rows");
		for (int i = alu_end; i < branch_end; i++)
			run_row(i);
		finish_test("branch rows");
		for (int i = branch_end; i < mem_end; i++)
			run_row(i);
		host_transfer(1'b0, 32'h84, 32'h0, hdata);
		check_value("host_rdata", hdata, 32'hdeadbeef);
		finish_test("memory round trip");

		// host keeps the bus busy while the load waits its turn.
		fork
			begin
				logic [31:0] rd;
				for (int k = 0; k < 4; k++) begin
					host_transfer(1'b0, 32'h40 + 4 * k, 32'h0, rd);
					check_value("host_rdata", rd, fill_word(32'h40 + 4 * k));
				end
			end
			run_row(contend_row);
		join
		finish_test("bus contention");

		check_value("halted", {31'b0, halted}, 32'd0);
		run_row(halt_row);
		repeat (3) begin
			@(negedge clk);
			check_value("halted", {31'b0, halted}, 32'd1);
		end
		@(posedge clk);
		#1;
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_value("halted", {31'b0, halted}, 32'd0);
		check_value("completed", {31'b0, completed}, 32'd0);
		finish_test("halt and reset");

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
isa_pkg.sv
bus_pkg.sv
mem_bus_if.sv
alu_exec_element.sv
branch_exec_element.sv
mem_exec_element.sv
executor.sv
bus_arbiter.sv
data_memory.sv
exec_unit_top.sv
exec_unit_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --timing --assert
TOP = exec_unit_tb
FILELIST = all.f
OBJ_DIR = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
